// File: design/dcache_pkg.sv
package dcache_pkg;

	// ========================================
	// Geometry and widths
	// ========================================

	// Byte address and data word
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;
	localparam int BE_W = 4;

	// Four ways of sixteen sets, each line holds four words
	localparam int WAYS = 4;
	localparam int WAY_W = 2;
	localparam int SETS = 16;
	localparam int INDEX_W = 4;
	localparam int WORDS_PER_LINE = 4;
	localparam int WORD_W = 2;
	localparam int TAG_W = 8;

	// Memory side addresses words, so the byte offset is dropped
	localparam int MEM_ADDR_W = 14;

	// ========================================
	// Controller state encoding
	// ========================================
	localparam int ST_W = 4;
	localparam logic [ST_W-1:0] ST_IDLE = 4'd0;
	localparam logic [ST_W-1:0] ST_LOOKUP = 4'd1;
	localparam logic [ST_W-1:0] ST_WB_REQ = 4'd2;
	localparam logic [ST_W-1:0] ST_WB_WAIT = 4'd3;
	localparam logic [ST_W-1:0] ST_RF_REQ = 4'd4;
	localparam logic [ST_W-1:0] ST_RF_WAIT = 4'd5;
	localparam logic [ST_W-1:0] ST_BYP_REQ = 4'd6;
	localparam logic [ST_W-1:0] ST_BYP_WAIT = 4'd7;
	localparam logic [ST_W-1:0] ST_RESPOND = 4'd8;
	localparam logic [ST_W-1:0] ST_RELEASE = 4'd9;

	// ========================================
	// Address decode
	// ========================================

	// Byte address split into cache fields, most significant first
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] index;
		logic [WORD_W-1:0] word;
		logic [ADDR_W-MEM_ADDR_W-1:0] byte_off;
	} dc_addr_fields_t;

	// The same sixteen bits seen as a flat address or as fields
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		dc_addr_fields_t fields;
	} dc_addr_u;

endpackage

// File: design/dcache_beat_counter.sv
`timescale 1ns/1ps

module dcache_beat_counter (
	input logic clk,
	input logic rst,
	input logic clear_i,
	input logic step_i,
	output logic [dcache_pkg::WORD_W-1:0] beat_o,
	output logic last_o
);
	import dcache_pkg::*;

	logic [WORD_W-1:0] beat_q;

	// Word position inside the line currently moving over the memory port
	// The count is exactly WORD_W bits wide, so it wraps to zero after the final word
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			beat_q <= '0;
		end else if (clear_i) begin
			beat_q <= '0;
		end else if (step_i) begin
			beat_q <= beat_q + 1'b1;
		end
	end

	assign beat_o = beat_q;

	// Final word of the line, so the controller knows when to leave its loop
	assign last_o = (beat_q == WORD_W'(WORDS_PER_LINE - 1));

	// The controller clears only in LOOKUP and steps only at the end of a word
	// handshake, so the two never meet
	a_clear_step_excl: assert property (
		@(posedge clk) disable iff (rst) !(clear_i && step_i)
	) else $error("beat counter cleared and stepped in the same cycle");

endmodule

// File: design/dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array (
	input logic clk,
	input logic rst,
	input logic [dcache_pkg::INDEX_W-1:0] index_i,
	input logic [dcache_pkg::TAG_W-1:0] tag_i,
	input logic fill_i,
	input logic dirty_set_i,
	input logic [dcache_pkg::WAY_W-1:0] dirty_way_i,
	input logic inv_all_i,
	output logic hit_o,
	output logic [dcache_pkg::WAY_W-1:0] hit_way_o,
	output logic [dcache_pkg::WAY_W-1:0] victim_way_o,
	output logic victim_dirty_o,
	output logic [dcache_pkg::TAG_W-1:0] victim_tag_o
);
	import dcache_pkg::*;

	logic [TAG_W-1:0] tag_q [WAYS][SETS];
	logic [SETS-1:0] valid_q [WAYS];
	logic [SETS-1:0] dirty_q [WAYS];

	// Round-robin replacement pointer of every set
	logic [WAY_W-1:0] rr_q [SETS];

	logic [WAYS-1:0] hit_vec;

	// ========================================
	// Lookup
	// ========================================

	// Compare the tag against every valid way of the addressed set
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			hit_vec[w] = valid_q[w][index_i] && (tag_q[w][index_i] == tag_i);
		end
	end

	assign hit_o = |hit_vec;

	// Encode the hit way
	// At most one bit is set, so the order of the scan does not matter
	always_comb begin
		hit_way_o = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (hit_vec[w]) begin
				hit_way_o = WAY_W'(w);
			end
		end
	end

	// The victim is whatever way the pointer names, valid or not
	// Only a valid and dirty victim needs a writeback
	assign victim_way_o = rr_q[index_i];
	assign victim_dirty_o = valid_q[rr_q[index_i]][index_i] && dirty_q[rr_q[index_i]][index_i];
	assign victim_tag_o = tag_q[rr_q[index_i]][index_i];

	// ========================================
	// Update
	// ========================================

	// Tag storage is only meaningful under a valid bit
	always_ff @(posedge clk) begin
		if (fill_i) begin
			tag_q[rr_q[index_i]][index_i] <= tag_i;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			for (int s = 0; s < SETS; s++) begin
				rr_q[s] <= '0;
			end
		end else begin
			// A refilled line starts clean and the pointer moves on to the next way
			if (fill_i) begin
				valid_q[rr_q[index_i]][index_i] <= 1'b1;
				dirty_q[rr_q[index_i]][index_i] <= 1'b0;
				rr_q[index_i] <= rr_q[index_i] + 1'b1;
			end
			if (dirty_set_i) begin
				dirty_q[dirty_way_i][index_i] <= 1'b1;
			end
			// Invalidate drops every line, dirty or not, without a writeback
			if (inv_all_i) begin
				for (int w = 0; w < WAYS; w++) begin
					valid_q[w] <= '0;
				end
			end
		end
	end

	// A fill always replaces the victim after a miss on the same tag, so no tag
	// can sit in two ways of one set
	a_hit_onehot: assert property (
		@(posedge clk) disable iff (rst) $onehot0(hit_vec)
	) else $error("tag found in more than one way");

endmodule

// File: design/dcache_data_array.sv
`timescale 1ns/1ps

module dcache_data_array (
	input logic clk,
	input logic we_i,
	input logic [dcache_pkg::WAY_W-1:0] way_i,
	input logic [dcache_pkg::INDEX_W-1:0] index_i,
	input logic [dcache_pkg::WORD_W-1:0] word_i,
	input logic [dcache_pkg::BE_W-1:0] be_i,
	input logic [dcache_pkg::DATA_W-1:0] wdata_i,
	output logic [dcache_pkg::DATA_W-1:0] rdata_o
);
	import dcache_pkg::*;

	localparam int ROW_W = INDEX_W + WORD_W;

	// One word per row, rows ordered by set and then by word within the line
	logic [DATA_W-1:0] mem_q [WAYS][SETS*WORDS_PER_LINE];
	dc_addr_u loc;
	logic [ROW_W-1:0] row;

	// ========================================
	// Row address
	// ========================================

	// Place index and word in an address and take the bits between tag and byte
	// offset, which gives the row inside one way
	always_comb begin
		loc.raw = '0;
		loc.fields.index = index_i;
		loc.fields.word = word_i;
	end

	assign row = loc.raw[ADDR_W-TAG_W-1:ADDR_W-MEM_ADDR_W];

	// ========================================
	// Storage
	// ========================================

	// Byte lanes are written on their own
	// A refill sets every enable, and a CPU write hit passes the CPU enables
	always_ff @(posedge clk) begin
		if (we_i) begin
			for (int b = 0; b < BE_W; b++) begin
				if (be_i[b]) begin
					mem_q[way_i][row][8*b +: 8] <= wdata_i[8*b +: 8];
				end
			end
		end
	end

	// Read is asynchronous, so a write becomes visible after the next edge
	assign rdata_o = mem_q[way_i][row];

endmodule

// File: design/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
	input logic clk,
	input logic rst,
	// CPU port
	input logic cpu_req_i,
	input logic cpu_we_i,
	input dcache_pkg::dc_addr_u cpu_addr_i,
	input logic [dcache_pkg::DATA_W-1:0] cpu_wdata_i,
	input logic [dcache_pkg::BE_W-1:0] cpu_be_i,
	input logic dce_i,
	input logic inv_all_i,
	output logic cpu_ack_o,
	output logic [dcache_pkg::DATA_W-1:0] cpu_rdata_o,
	// Memory port
	output logic mem_req_o,
	output logic mem_we_o,
	output logic [dcache_pkg::MEM_ADDR_W-1:0] mem_addr_o,
	output logic [dcache_pkg::DATA_W-1:0] mem_wdata_o,
	output logic [dcache_pkg::BE_W-1:0] mem_be_o,
	input logic mem_ack_i,
	input logic [dcache_pkg::DATA_W-1:0] mem_rdata_i,
	// Tag array
	input logic hit_i,
	input logic [dcache_pkg::WAY_W-1:0] hit_way_i,
	input logic [dcache_pkg::WAY_W-1:0] victim_way_i,
	input logic victim_dirty_i,
	input logic [dcache_pkg::TAG_W-1:0] victim_tag_i,
	output logic [dcache_pkg::INDEX_W-1:0] look_index_o,
	output logic [dcache_pkg::TAG_W-1:0] look_tag_o,
	output logic fill_o,
	output logic dirty_set_o,
	output logic [dcache_pkg::WAY_W-1:0] dirty_way_o,
	output logic inv_o,
	// Data array
	output logic arr_we_o,
	output logic [dcache_pkg::WAY_W-1:0] arr_way_o,
	output logic [dcache_pkg::WORD_W-1:0] arr_word_o,
	output logic [dcache_pkg::BE_W-1:0] arr_be_o,
	output logic [dcache_pkg::DATA_W-1:0] arr_wdata_o,
	input logic [dcache_pkg::DATA_W-1:0] arr_rdata_i,
	// Beat counter
	output logic beat_clear_o,
	output logic beat_step_o,
	input logic [dcache_pkg::WORD_W-1:0] beat_i,
	input logic last_i
);
	import dcache_pkg::*;

	logic [ST_W-1:0] state_q;

	// Request held for the whole transaction
	logic req_we_q;
	dc_addr_u req_addr_q;
	logic [DATA_W-1:0] req_wdata_q;
	logic [BE_W-1:0] req_be_q;
	logic [WAY_W-1:0] hit_way_q;

	// Memory address of the current line beat
	dc_addr_u line_addr;

	// Both memory wires low again means the word handshake has closed
	logic mem_idle;
	logic respond_wr;

	// Bytes of the new word replace the old ones where the enable is set
	function automatic logic [DATA_W-1:0] be_merge(
		input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] new_w,
		input logic [BE_W-1:0] be
	);
		logic [DATA_W-1:0] res;
		res = old_w;
		for (int b = 0; b < BE_W; b++) begin
			if (be[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	assign mem_idle = !mem_req_o && !mem_ack_i;
	assign respond_wr = (state_q == ST_RESPOND) && req_we_q;

	// Writeback uses the victim's tag, refill the request's tag
	always_comb begin
		line_addr.fields.tag = (state_q == ST_WB_REQ) ? victim_tag_i : req_addr_q.fields.tag;
		line_addr.fields.index = req_addr_q.fields.index;
		line_addr.fields.word = beat_i;
		line_addr.fields.byte_off = '0;
	end

	// ========================================
	// Steering of the arrays and counter
	// ========================================
	assign look_index_o = req_addr_q.fields.index;
	assign look_tag_o = req_addr_q.fields.tag;
	assign inv_o = (state_q == ST_IDLE) && !cpu_req_i && inv_all_i;
	assign dirty_set_o = respond_wr;
	assign dirty_way_o = hit_way_q;

	// The pointer stays put until the fill, so the victim way is stable all
	// through writeback and refill
	assign fill_o = (state_q == ST_RF_WAIT) && mem_idle && last_i;
	assign beat_clear_o = (state_q == ST_LOOKUP);
	assign beat_step_o = ((state_q == ST_WB_WAIT) || (state_q == ST_RF_WAIT)) && mem_idle;

	// Refill words go in as the memory acknowledges them
	assign arr_we_o = ((state_q == ST_RF_WAIT) && mem_req_o && mem_ack_i) || respond_wr;
	assign arr_way_o = (state_q == ST_RESPOND) ? hit_way_q : victim_way_i;
	assign arr_word_o = (state_q == ST_RESPOND) ? req_addr_q.fields.word : beat_i;
	assign arr_be_o = (state_q == ST_RESPOND) ? req_be_q : '1;
	assign arr_wdata_o = (state_q == ST_RESPOND) ? req_wdata_q : mem_rdata_i;

	// ========================================
	// State machine
	// ========================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= ST_IDLE;
			cpu_ack_o <= 1'b0;
			mem_req_o <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (cpu_req_i) begin
						state_q <= dce_i ? ST_LOOKUP : ST_BYP_REQ;
					end
				end
				ST_LOOKUP: begin
					if (hit_i) begin
						state_q <= ST_RESPOND;
					end else begin
						state_q <= victim_dirty_i ? ST_WB_REQ : ST_RF_REQ;
					end
				end
				ST_WB_REQ: begin
					mem_req_o <= 1'b1;
					state_q <= ST_WB_WAIT;
				end
				ST_WB_WAIT: begin
					if (mem_req_o && mem_ack_i) begin
						mem_req_o <= 1'b0;
					end else if (mem_idle) begin
						state_q <= last_i ? ST_RF_REQ : ST_WB_REQ;
					end
				end
				ST_RF_REQ: begin
					mem_req_o <= 1'b1;
					state_q <= ST_RF_WAIT;
				end
				ST_RF_WAIT: begin
					// After the last word the lookup runs again and hits
					if (mem_req_o && mem_ack_i) begin
						mem_req_o <= 1'b0;
					end else if (mem_idle) begin
						state_q <= last_i ? ST_LOOKUP : ST_RF_REQ;
					end
				end
				ST_BYP_REQ: begin
					mem_req_o <= 1'b1;
					state_q <= ST_BYP_WAIT;
				end
				ST_BYP_WAIT: begin
					if (mem_req_o && mem_ack_i) begin
						mem_req_o <= 1'b0;
					end else if (mem_idle) begin
						cpu_ack_o <= 1'b1;
						state_q <= ST_RELEASE;
					end
				end
				ST_RESPOND: begin
					cpu_ack_o <= 1'b1;
					state_q <= ST_RELEASE;
				end
				ST_RELEASE: begin
					// Ack follows req down
					if (!cpu_req_i) begin
						cpu_ack_o <= 1'b0;
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// ========================================
	// Request and bus payload
	// ========================================
	always_ff @(posedge clk) begin
		if ((state_q == ST_IDLE) && cpu_req_i) begin
			req_we_q <= cpu_we_i;
			req_addr_q <= cpu_addr_i;
			req_wdata_q <= cpu_wdata_i;
			req_be_q <= cpu_be_i;
		end
		if (state_q == ST_LOOKUP) begin
			hit_way_q <= hit_way_i;
		end
		case (state_q)
			ST_WB_REQ, ST_RF_REQ: begin
				// Array output is the victim word during writeback
				mem_we_o <= (state_q == ST_WB_REQ);
				mem_addr_o <= line_addr.raw[ADDR_W-1:ADDR_W-MEM_ADDR_W];
				mem_wdata_o <= arr_rdata_i;
				mem_be_o <= '1;
			end
			ST_BYP_REQ: begin
				mem_we_o <= req_we_q;
				mem_addr_o <= req_addr_q.raw[ADDR_W-1:ADDR_W-MEM_ADDR_W];
				mem_wdata_o <= req_wdata_q;
				mem_be_o <= req_be_q;
			end
			ST_BYP_WAIT: begin
				if (mem_req_o && mem_ack_i) begin
					cpu_rdata_o <= mem_rdata_i;
				end
			end
			ST_RESPOND: begin
				// A write hit returns the word as it will read after the update
				cpu_rdata_o <= req_we_q ? be_merge(arr_rdata_i, req_wdata_q, req_be_q)
					: arr_rdata_i;
			end
			default: begin
			end
		endcase
	end

	// Every memory handshake is closed before the machine comes back to IDLE
	a_no_mem_req_idle: assert property (
		@(posedge clk) disable iff (rst) (state_q == ST_IDLE) |-> !mem_req_o
	) else $error("memory request left open in IDLE");

endmodule

// File: design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
	input logic clk,
	input logic rst,
	// CPU port
	input logic cpu_req_i,
	input logic cpu_we_i,
	input dcache_pkg::dc_addr_u cpu_addr_i,
	input logic [dcache_pkg::DATA_W-1:0] cpu_wdata_i,
	input logic [dcache_pkg::BE_W-1:0] cpu_be_i,
	output logic cpu_ack_o,
	output logic [dcache_pkg::DATA_W-1:0] cpu_rdata_o,
	input logic dce_i,
	input logic inv_all_i,
	// Memory port
	output logic mem_req_o,
	output logic mem_we_o,
	output logic [dcache_pkg::MEM_ADDR_W-1:0] mem_addr_o,
	output logic [dcache_pkg::DATA_W-1:0] mem_wdata_o,
	output logic [dcache_pkg::BE_W-1:0] mem_be_o,
	input logic mem_ack_i,
	input logic [dcache_pkg::DATA_W-1:0] mem_rdata_i
);
	import dcache_pkg::*;

	// Tag array results and updates
	logic hit;
	logic [WAY_W-1:0] hit_way;
	logic [WAY_W-1:0] victim_way;
	logic victim_dirty;
	logic [TAG_W-1:0] victim_tag;
	logic [INDEX_W-1:0] look_index;
	logic [TAG_W-1:0] look_tag;
	logic fill;
	logic dirty_set;
	logic [WAY_W-1:0] dirty_way;
	logic inv;

	// Data array access
	logic arr_we;
	logic [WAY_W-1:0] arr_way;
	logic [WORD_W-1:0] arr_word;
	logic [BE_W-1:0] arr_be;
	logic [DATA_W-1:0] arr_wdata;
	logic [DATA_W-1:0] arr_rdata;

	// Line beat position
	logic beat_clear;
	logic beat_step;
	logic [WORD_W-1:0] beat;
	logic last;

	dcache_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.cpu_req_i(cpu_req_i), .cpu_we_i(cpu_we_i), .cpu_addr_i(cpu_addr_i),
		.cpu_wdata_i(cpu_wdata_i), .cpu_be_i(cpu_be_i),
		.dce_i(dce_i), .inv_all_i(inv_all_i),
		.cpu_ack_o(cpu_ack_o), .cpu_rdata_o(cpu_rdata_o),
		.mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o), .mem_be_o(mem_be_o),
		.mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i),
		.hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
		.victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag),
		.look_index_o(look_index), .look_tag_o(look_tag), .fill_o(fill),
		.dirty_set_o(dirty_set), .dirty_way_o(dirty_way), .inv_o(inv),
		.arr_we_o(arr_we), .arr_way_o(arr_way), .arr_word_o(arr_word),
		.arr_be_o(arr_be), .arr_wdata_o(arr_wdata), .arr_rdata_i(arr_rdata),
		.beat_clear_o(beat_clear), .beat_step_o(beat_step),
		.beat_i(beat), .last_i(last)
	);

	dcache_beat_counter u_beat (
		.clk(clk), .rst(rst),
		.clear_i(beat_clear), .step_i(beat_step),
		.beat_o(beat), .last_o(last)
	);

	dcache_tag_array u_tags (
		.clk(clk), .rst(rst),
		.index_i(look_index), .tag_i(look_tag),
		.fill_i(fill), .dirty_set_i(dirty_set), .dirty_way_i(dirty_way),
		.inv_all_i(inv),
		.hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
		.victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag)
	);

	// The data array shares the lookup index, since every access is to the
	// set of the held request
	dcache_data_array u_data (
		.clk(clk), .we_i(arr_we), .way_i(arr_way),
		.index_i(look_index), .word_i(arr_word),
		.be_i(arr_be), .wdata_i(arr_wdata), .rdata_o(arr_rdata)
	);

endmodule

// File: tests/dcache_mem_model.sv
`timescale 1ns/1ps

module dcache_mem_model (
	input logic clk,
	input logic rst,
	input logic req_i,
	input logic we_i,
	input logic [dcache_pkg::MEM_ADDR_W-1:0] addr_i,
	input logic [dcache_pkg::DATA_W-1:0] wdata_i,
	input logic [dcache_pkg::BE_W-1:0] be_i,
	output logic ack_o,
	output logic [dcache_pkg::DATA_W-1:0] rdata_o
);
	import dcache_pkg::*;

	localparam int ACK_DELAY = 2;

	// Whole word space, readable from the testbench by hierarchical name
	logic [DATA_W-1:0] words [2**MEM_ADDR_W];
	int wait_cnt;

	// Every word starts as a multiplicative hash of its own word address
	initial begin
		for (int w = 0; w < 2**MEM_ADDR_W; w++) begin
			words[w] = w * 32'h9E3779B1;
		end
	end

	// Four-phase responder
	// A request waits ACK_DELAY cycles, then ack rises with the access done,
	// and ack falls once the cache has dropped its request
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			ack_o <= 1'b0;
			rdata_o <= '0;
			wait_cnt <= 0;
		end else if (req_i && !ack_o) begin
			if (wait_cnt == ACK_DELAY - 1) begin
				wait_cnt <= 0;
				ack_o <= 1'b1;
				if (we_i) begin
					for (int b = 0; b < BE_W; b++) begin
						if (be_i[b]) begin
							words[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
						end
					end
				end else begin
					rdata_o <= words[addr_i];
				end
			end else begin
				wait_cnt <= wait_cnt + 1;
			end
		end else if (!req_i && ack_o) begin
			ack_o <= 1'b0;
		end
	end

endmodule

// File: tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
	import dcache_pkg::*;

	// About 320 transactions of at most about 80 cycles each fit well inside
	localparam int CYCLE_LIMIT = 40000;
	// Req is driven on edge 0, sampled on edge 1, and a hit raises ack two edges later
	localparam int HIT_ACK_EDGE = 3;
	localparam int RANDOM_OPS = 300;
	localparam logic [31:0] LCG_SEED = 32'h7f49cf20;

	logic clk = 1'b0;
	logic rst;
	logic cpu_req;
	logic cpu_we;
	dc_addr_u cpu_addr;
	logic [DATA_W-1:0] cpu_wdata;
	logic [BE_W-1:0] cpu_be;
	logic cpu_ack;
	logic [DATA_W-1:0] cpu_rdata;
	logic dce;
	logic inv_all;
	logic mem_req;
	logic mem_we;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata;
	logic [BE_W-1:0] mem_be;
	logic mem_ack;
	logic [DATA_W-1:0] mem_rdata;

	// Shadow of every word as the CPU should see it
	logic [DATA_W-1:0] shadow [2**MEM_ADDR_W];
	// Expected CPU data in request order, with a flag for the responses that are compared
	logic [DATA_W-1:0] exp_q [$];
	logic chk_q [$];
	// Words seen on the memory port
	logic [MEM_ADDR_W-1:0] mon_addr_q [$];
	logic [DATA_W-1:0] mon_wdata_q [$];
	logic [BE_W-1:0] mon_be_q [$];
	logic mon_we_q [$];
	logic [31:0] lcg_state;
	logic ack_prev;
	logic [DATA_W-1:0] exp_word;
	logic exp_chk;
	int cycles = 0;
	int errors = 0;
	int checks = 0;

	dcache_top dut (
		.clk(clk), .rst(rst),
		.cpu_req_i(cpu_req), .cpu_we_i(cpu_we), .cpu_addr_i(cpu_addr),
		.cpu_wdata_i(cpu_wdata), .cpu_be_i(cpu_be),
		.cpu_ack_o(cpu_ack), .cpu_rdata_o(cpu_rdata),
		.dce_i(dce), .inv_all_i(inv_all),
		.mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata), .mem_be_o(mem_be),
		.mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata)
	);

	dcache_mem_model mem (
		.clk(clk), .rst(rst),
		.req_i(mem_req), .we_i(mem_we), .addr_i(mem_addr),
		.wdata_i(mem_wdata), .be_i(mem_be),
		.ack_o(mem_ack), .rdata_o(mem_rdata)
	);

	always #10 clk = ~clk;

	// ========================================
	// Helpers and reference model
	// ========================================
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Initial memory contents by the same hash rule the memory follows
	function automatic logic [DATA_W-1:0] mem_rule(input int w);
		return w * 32'h9E3779B1;
	endfunction

	function automatic dc_addr_u make_addr(input logic [TAG_W-1:0] tag,
		input logic [INDEX_W-1:0] index, input logic [WORD_W-1:0] word);
		dc_addr_u a;
		a.fields.tag = tag;
		a.fields.index = index;
		a.fields.word = word;
		a.fields.byte_off = '0;
		return a;
	endfunction

	// A write merges its enabled bytes into the shadow word, and either access
	// returns the word as the CPU sees it afterwards
	function automatic logic [DATA_W-1:0] ref_access(input logic we, input dc_addr_u addr,
		input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be);
		logic [MEM_ADDR_W-1:0] w;
		w = addr.raw[ADDR_W-1:ADDR_W-MEM_ADDR_W];
		if (we) begin
			for (int b = 0; b < BE_W; b++) begin
				if (be[b]) begin
					shadow[w][8*b +: 8] = wdata[8*b +: 8];
				end
			end
		end
		return shadow[w];
	endfunction

	task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input dc_addr_u got, input dc_addr_u exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s address got %h (tag %h set %h word %h) expected %h",
				$time, what, got.raw, got.fields.tag, got.fields.index, got.fields.word,
				exp.raw);
		end
	endtask

	task automatic clear_monitor();
		mon_addr_q.delete();
		mon_wdata_q.delete();
		mon_be_q.delete();
		mon_we_q.delete();
	endtask

	// One full four-phase CPU transaction
	// ack_edge is the edge after the drive edge on which ack rose
	task automatic cpu_access(input logic cached, input logic we, input dc_addr_u addr,
		input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be, output int ack_edge);
		int edges;
		exp_q.push_back(ref_access(we, addr, wdata, be));
		// A cached write answers with the merged word, an uncached write with nothing
		chk_q.push_back(cached || !we);
		@(posedge clk);
		cpu_req <= 1'b1;
		dce <= cached;
		cpu_we <= we;
		cpu_addr <= addr;
		cpu_wdata <= wdata;
		cpu_be <= be;
		edges = 0;
		do begin
			@(posedge clk);
			edges++;
		end while (!cpu_ack);
		ack_edge = edges - 1;
		cpu_req <= 1'b0;
		do begin
			@(posedge clk);
		end while (cpu_ack);
	endtask

	// An uncached access is exactly one memory word at its own address
	task automatic check_bypass(input dc_addr_u a, input logic we, input logic [BE_W-1:0] be);
		dc_addr_u got;
		check_word(DATA_W'(mon_addr_q.size()), DATA_W'(1), "memory words for a bypass");
		got.raw = {mon_addr_q[0], 2'b00};
		check_addr(got, a, "bypass");
		check_word(DATA_W'(mon_be_q[0]), DATA_W'(be), "bypass byte enables");
		check_word(DATA_W'(mon_we_q[0]), DATA_W'(we), "bypass direction");
	endtask

	// Dirty lines are dropped, so the CPU view falls back to what memory holds
	task automatic invalidate_all();
		@(posedge clk);
		inv_all <= 1'b1;
		@(posedge clk);
		inv_all <= 1'b0;
		@(posedge clk);
		for (int w = 0; w < 2**MEM_ADDR_W; w++) begin
			shadow[w] = mem.words[w];
		end
	endtask

	// ========================================
	// Monitors, compare and timeout
	// ========================================

	// Req and ack are both high on exactly one edge of every memory word
	always @(posedge clk) begin
		if (mem_req && mem_ack) begin
			mon_addr_q.push_back(mem_addr);
			mon_wdata_q.push_back(mem_wdata);
			mon_be_q.push_back(mem_be);
			mon_we_q.push_back(mem_we);
		end
	end

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			ack_prev <= 1'b0;
		end else begin
			ack_prev <= cpu_ack;
			if (cpu_ack && !ack_prev) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Error at %0t: CPU ack rose with no request outstanding", $time);
				end else begin
					exp_word = exp_q.pop_front();
					exp_chk = chk_q.pop_front();
					if (exp_chk) begin
						check_word(cpu_rdata, exp_word, $sformatf("access of %h", cpu_addr.raw));
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run still busy after %0d cycles with %0d errors", cycles, errors);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ========================================
	// Stimulus
	// ========================================
	initial begin
		dc_addr_u a;
		dc_addr_u exp_a;
		dc_addr_u got_a;
		logic [31:0] r;
		logic [DATA_W-1:0] d;
		logic [BE_W-1:0] be;
		int ack_edge;
		lcg_state = LCG_SEED;
		rst = 1'b1;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_be = '0;
		dce = 1'b1;
		inv_all = 1'b0;
		for (int w = 0; w < 2**MEM_ADDR_W; w++) begin
			shadow[w] = mem_rule(w);
		end
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// Miss then hit on a fresh line, the hit makes no memory traffic
		a = make_addr(8'h01, 4'h0, 2'd1);
		cpu_access(1'b1, 1'b0, a, '0, '0, ack_edge);
		clear_monitor();
		cpu_access(1'b1, 1'b0, a, '0, '0, ack_edge);
		check_word(DATA_W'(ack_edge), DATA_W'(HIT_ACK_EDGE), "hit ack edge");
		check_word(DATA_W'(mon_addr_q.size()), '0, "memory words on a hit");

		// First write allocates the line, later ones hit it
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			a = make_addr(8'h02, 4'h1, WORD_W'(i));
			d = lcg_next();
			r = lcg_next();
			cpu_access(1'b1, 1'b1, a, d, r[31:28], ack_edge);
			cpu_access(1'b1, 1'b0, a, '0, '0, ack_edge);
		end

		// Five tags in set F, the fifth pushes out the dirty line in way 0
		a = make_addr(8'h20, 4'hF, 2'd2);
		cpu_access(1'b1, 1'b1, a, lcg_next(), 4'hF, ack_edge);
		for (int t = 1; t < WAYS; t++) begin
			cpu_access(1'b1, 1'b0, make_addr(TAG_W'(8'h20 + t), 4'hF, 2'd0), '0, '0, ack_edge);
		end
		clear_monitor();
		cpu_access(1'b1, 1'b0, make_addr(8'h24, 4'hF, 2'd0), '0, '0, ack_edge);
		check_word(DATA_W'(mon_addr_q.size()), DATA_W'(2 * WORDS_PER_LINE),
			"memory words for a dirty eviction");
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			exp_a = make_addr(8'h20, 4'hF, WORD_W'(w));
			got_a.raw = {mon_addr_q[w], 2'b00};
			check_addr(got_a, exp_a, "writeback");
			check_word(mon_wdata_q[w], shadow[exp_a.raw[ADDR_W-1:ADDR_W-MEM_ADDR_W]],
				"writeback data");
			check_word(DATA_W'(mon_we_q[w]), DATA_W'(1), "writeback direction");
		end
		cpu_access(1'b1, 1'b0, a, '0, '0, ack_edge);

		// Uncached range has tags from 8'h80 up and never enters the cache
		a = make_addr(8'h90, 4'h5, 2'd3);
		d = lcg_next();
		r = lcg_next();
		be = r[31:28];
		clear_monitor();
		cpu_access(1'b0, 1'b1, a, d, be, ack_edge);
		check_bypass(a, 1'b1, be);
		clear_monitor();
		cpu_access(1'b0, 1'b0, a, '0, 4'hF, ack_edge);
		check_bypass(a, 1'b0, 4'hF);

		// A dirty line that was never evicted loses its data on invalidate
		a = make_addr(8'h30, 4'h3, 2'd0);
		cpu_access(1'b1, 1'b1, a, ~shadow[a.raw[ADDR_W-1:ADDR_W-MEM_ADDR_W]], 4'hF, ack_edge);
		invalidate_all();
		cpu_access(1'b1, 1'b0, a, '0, '0, ack_edge);
		cpu_access(1'b1, 1'b0, make_addr(8'h20, 4'hF, 2'd2), '0, '0, ack_edge);

		// Eight tags over sixteen sets give twice the lines the cache can hold
		for (int i = 0; i < RANDOM_OPS; i++) begin
			r = lcg_next();
			a = make_addr({5'b01000, r[31:29]}, r[28:25], r[24:23]);
			if (r[17:12] == 6'd0) begin
				invalidate_all();
			end
			cpu_access(1'b1, r[22], a, lcg_next(), r[21:18], ack_edge);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: src.f
design/dcache_pkg.sv
design/dcache_beat_counter.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tests/dcache_mem_model.sv
tests/tb_dcache.sv

// File: Makefile
# Verilator build and run of the data cache testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP ?= tb_dcache
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
